// File: all.f
verilog/armCorePkg.sv
verilog/coreCtrlIf.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/operandShifter.sv
verilog/controlSequencer.sv
verilog/coreDatapath.sv
verilog/armCore.sv
tb/memoryModel.sv
tb/armCoreTb.sv

// File: Makefile
# Verilator flow for the ARM subset core

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= armCoreTb
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Finished with no errors
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/armCoreTb.sv
`default_nettype none

module armCoreTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AddrWidth = 16;
  // Four tests hold 52, 17, 8 and 6 instructions
  localparam int TotalInstr = 83;
  localparam int CycleLimit = TotalInstr * 12 + 4 * (16 + 30);
  localparam logic [3:0] WriteOps [12] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5,
                                          4'h6, 4'h7, 4'hC, 4'hD, 4'hE, 4'hF};

  logic                 clk = 1'b0;
  logic                 reset = 1'b1;
  logic                 memValid;
  logic                 memWrite;
  logic [AddrWidth-1:0] memAddr;
  logic [31:0]          memWriteData;
  logic [31:0]          memReadData;
  logic                 memReady;
  logic                 halted;

  logic [31:0] seed = 32'hddd1bcd6;
  logic [31:0] prog [$];
  logic [31:0] dataAddr [$];
  logic [31:0] dataVal [$];
  int          cycleCount = 0;
  logic        pending = 1'b0;
  logic [31:0] heldAddr;
  logic        heldWrite;
  logic [31:0] heldData;

  armCore #(.AddrWidth(AddrWidth)) UUT (
    .clk(clk), .reset(reset), .memValid(memValid), .memWrite(memWrite),
    .memAddr(memAddr), .memWriteData(memWriteData), .memReadData(memReadData),
    .memReady(memReady), .halted(halted)
  );

  memoryModel #(.AddrWidth(AddrWidth)) memory (
    .clk(clk), .reset(reset), .memValid(memValid), .memWrite(memWrite),
    .memAddr(memAddr), .memWriteData(memWriteData), .memReadData(memReadData),
    .memReady(memReady)
  );

  initial
  begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > CycleLimit)
    begin
      $display("Timeout: the core did not halt within %0d cycles", CycleLimit);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // A request must hold still until memReady
  always @(posedge clk)
  begin
    if (!reset && pending)
    begin
      checkValue("memValid", 32'(memValid), 32'd1);
      checkValue("memAddr", 32'(memAddr), heldAddr);
      checkValue("memWrite", 32'(memWrite), 32'(heldWrite));
      if (heldWrite)
        checkValue("memWriteData", memWriteData, heldData);
    end
    pending   = !reset && memValid && !memReady;
    heldAddr  = 32'(memAddr);
    heldWrite = memWrite;
    heldData  = memWriteData;
  end

  function logic [31:0] nextRandom();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] op, input logic s,
                                        input logic [3:0] rd, input logic [3:0] rn,
                                        input logic [3:0] rm);
    return {4'hE, 3'b000, op, s, rn, rd, 8'h00, rm};
  endfunction

  function automatic logic [31:0] dpImm(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [3:0] rot,
                                        input logic [7:0] imm8);
    return {4'hE, 3'b001, op, 1'b0, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] loadInstr(input logic [3:0] rd, input logic [3:0] rn,
                                            input logic [11:0] off);
    return {4'hE, 8'h59, rn, rd, off};
  endfunction

  function automatic logic [31:0] storeInstr(input logic [3:0] rd, input logic [3:0] rn,
                                             input logic [11:0] off);
    return {4'hE, 8'h58, rn, rd, off};
  endfunction

  function automatic logic [31:0] branchInstr(input logic [23:0] off);
    return {8'hEA, off};
  endfunction

  function automatic logic [31:0] rotateImm(input logic [7:0] imm8, input logic [3:0] rot);
    logic [31:0] x;
    int          r;
    x = {24'd0, imm8};
    r = 2 * int'(rot);
    if (r == 0)
      return x;
    return (x >> r) | (x << (32 - r));
  endfunction

  // Expected value of Rd by the ARM opcode rules
  function automatic logic [31:0] expectDp(input logic [3:0] op, input logic [31:0] a,
                                           input logic [31:0] b, input logic cin);
    logic [31:0] notBorrow;
    notBorrow = cin ? 32'd0 : 32'd1;
    case (op)
      4'h0: return a & b;
      4'h1: return a ^ b;
      4'h2: return a - b;
      4'h3: return b - a;
      4'h4: return a + b;
      4'h5: return a + b + 32'(cin);
      4'h6: return a - b - notBorrow;
      4'h7: return b - a - notBorrow;
      4'hC: return a | b;
      4'hD: return b;
      4'hE: return a & ~b;
      default: return ~b;
    endcase
  endfunction

  function automatic logic [11:0] slot(input logic [11:0] base, input int k);
    return base + 12'(4 * k);
  endfunction

  task automatic runProgram();
    @(negedge clk);
    reset = 1'b1;
    memory.fill();
    foreach (prog[i])
      memory.writeWord(32'(4 * i), prog[i]);
    foreach (dataAddr[i])
      memory.writeWord(dataAddr[i], dataVal[i]);
    for (int i = 0; i < 16; i++)
    begin
      @(negedge clk);
      checkValue("memValid", 32'(memValid), 32'd0);
      checkValue("memWrite", 32'(memWrite), 32'd0);
      checkValue("halted", 32'(halted), 32'd0);
    end
    reset = 1'b0;
    // First request after reset reads address 0
    @(negedge clk);
    checkValue("memValid", 32'(memValid), 32'd1);
    checkValue("memWrite", 32'(memWrite), 32'd0);
    checkValue("memAddr", 32'(memAddr), 32'd0);
    while (!halted)
      @(negedge clk);
  endtask

  task automatic clearProgram();
    prog.delete();
    dataAddr.delete();
    dataVal.delete();
    prog.push_back(dpImm(4'hD, 4'd0, 4'd0, 4'd0, 8'd0));
  endtask

  task automatic dataProcTest();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    logic [7:0]  immVal [12];
    logic [3:0]  rotVal [12];
    clearProgram();
    a = nextRandom();
    b = nextRandom();
    dataAddr.push_back(32'h800);
    dataVal.push_back(a);
    dataAddr.push_back(32'h804);
    dataVal.push_back(b);
    prog.push_back(loadInstr(4'd1, 4'd0, 12'h800));
    prog.push_back(loadInstr(4'd2, 4'd0, 12'h804));
    for (int k = 0; k < 12; k++)
    begin
      prog.push_back(dpReg(WriteOps[k], 1'b0, 4'd3, 4'd1, 4'd2));
      prog.push_back(storeInstr(4'd3, 4'd0, slot(12'h900, k)));
    end
    for (int k = 0; k < 12; k++)
    begin
      rnd       = nextRandom();
      immVal[k] = rnd[7:0];
      rotVal[k] = rnd[11:8];
      prog.push_back(dpImm(WriteOps[k], 4'd3, 4'd1, rotVal[k], immVal[k]));
      prog.push_back(storeInstr(4'd3, 4'd0, slot(12'hA00, k)));
    end
    prog.push_back(branchInstr(24'hFF_FFFF));
    runProgram();
    for (int k = 0; k < 12; k++)
    begin
      checkValue($sformatf("register op %h", WriteOps[k]),
                 memory.readWord(32'(slot(12'h900, k))),
                 expectDp(WriteOps[k], a, b, 1'b0));
      checkValue($sformatf("immediate op %h", WriteOps[k]),
                 memory.readWord(32'(slot(12'hA00, k))),
                 expectDp(WriteOps[k], a, rotateImm(immVal[k], rotVal[k]), 1'b0));
    end
  endtask

  task automatic carryTest();
    clearProgram();
    dataAddr.push_back(32'h800);
    dataVal.push_back(32'hFFFF_FFF0);
    dataAddr.push_back(32'h804);
    dataVal.push_back(32'h0000_0020);
    prog.push_back(loadInstr(4'd1, 4'd0, 12'h800));
    prog.push_back(loadInstr(4'd2, 4'd0, 12'h804));
    prog.push_back(dpReg(4'h4, 1'b1, 4'd3, 4'd1, 4'd2));
    prog.push_back(storeInstr(4'd3, 4'd0, 12'h900));
    prog.push_back(dpReg(4'h5, 1'b0, 4'd4, 4'd2, 4'd2));
    prog.push_back(storeInstr(4'd4, 4'd0, 12'h904));
    prog.push_back(dpReg(4'h2, 1'b1, 4'd3, 4'd2, 4'd1));
    prog.push_back(storeInstr(4'd3, 4'd0, 12'h908));
    prog.push_back(dpReg(4'h6, 1'b0, 4'd4, 4'd2, 4'd2));
    prog.push_back(storeInstr(4'd4, 4'd0, 12'h90C));
    prog.push_back(dpReg(4'h7, 1'b0, 4'd4, 4'd2, 4'd1));
    prog.push_back(storeInstr(4'd4, 4'd0, 12'h910));
    prog.push_back(dpReg(4'hA, 1'b1, 4'd0, 4'd1, 4'd2));
    prog.push_back(dpReg(4'h5, 1'b0, 4'd4, 4'd2, 4'd2));
    prog.push_back(storeInstr(4'd4, 4'd0, 12'h914));
    prog.push_back(branchInstr(24'hFF_FFFF));
    runProgram();
    // ADDS carries out, SUBS borrows, CMP does not borrow
    checkValue("ADDS result", memory.readWord(32'h900), 32'h0000_0010);
    checkValue("ADC with carry", memory.readWord(32'h904), 32'h0000_0041);
    checkValue("SUBS result", memory.readWord(32'h908), 32'h0000_0030);
    checkValue("SBC with borrow", memory.readWord(32'h90C), 32'hFFFF_FFFF);
    checkValue("RSC with borrow", memory.readWord(32'h910), 32'hFFFF_FFCF);
    checkValue("ADC after CMP", memory.readWord(32'h914), 32'h0000_0041);
  endtask

  task automatic loadStoreTest();
    logic [31:0] word;
    clearProgram();
    word = nextRandom();
    dataAddr.push_back(32'h800);
    dataVal.push_back(word);
    prog.push_back(loadInstr(4'd5, 4'd0, 12'h800));
    prog.push_back(storeInstr(4'd5, 4'd0, 12'h904));
    prog.push_back(loadInstr(4'd6, 4'd0, 12'h904));
    prog.push_back(storeInstr(4'd6, 4'd0, 12'h908));
    prog.push_back(dpImm(4'hD, 4'd7, 4'd0, 4'd12, 8'h01));
    prog.push_back(storeInstr(4'd5, 4'd7, 12'h234));
    prog.push_back(branchInstr(24'hFF_FFFF));
    runProgram();
    checkValue("stored word", memory.readWord(32'h904), word);
    checkValue("round trip word", memory.readWord(32'h908), word);
    checkValue("word at base plus offset", memory.readWord(32'h334), word);
  endtask

  task automatic branchTest();
    logic [31:0] untouched;
    clearProgram();
    prog.push_back(dpImm(4'hD, 4'd1, 4'd0, 4'd0, 8'h55));
    prog.push_back(branchInstr(24'd1));
    prog.push_back(storeInstr(4'd1, 4'd0, 12'h900));
    prog.push_back(storeInstr(4'd1, 4'd0, 12'h904));
    prog.push_back(branchInstr(24'hFF_FFFF));
    memory.fill();
    untouched = memory.readWord(32'h900);
    runProgram();
    checkValue("skipped store", memory.readWord(32'h900), untouched);
    checkValue("store after branch", memory.readWord(32'h904), 32'h0000_0055);
    repeat (20)
    begin
      @(negedge clk);
      checkValue("memValid", 32'(memValid), 32'd0);
      checkValue("halted", 32'(halted), 32'd1);
    end
  endtask

  initial
  begin
    dataProcTest();
    carryTest();
    loadStoreTest();
    branchTest();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/memoryModel.sv
`default_nettype none

module memoryModel #(
  parameter int AddrWidth = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 memValid,
  input  logic                 memWrite,
  input  logic [AddrWidth-1:0] memAddr,
  input  logic [31:0]          memWriteData,
  output logic [31:0]          memReadData = 32'd0,
  output logic                 memReady = 1'b0
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int Words = 2 ** (AddrWidth - 2);

  logic [31:0] mem [Words];
  logic [31:0] delaySeed = 32'hddd1bcd6;
  logic        active = 1'b0;
  logic        waiting = 1'b0;
  int          waitLeft = 0;

  function logic [1:0] pickDelay();
    delaySeed = delaySeed * 32'd1664525 + 32'd1013904223;
    return delaySeed[17:16];
  endfunction

  // Pattern mixes every address bit
  task automatic fill();
    for (int i = 0; i < Words; i++)
      mem[i] = 32'hA5C3_0000 ^ (32'(i) * 32'h9E37_79B1);
  endtask

  task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[AddrWidth-1:2]] = data;
  endtask

  function automatic logic [31:0] readWord(input logic [31:0] addr);
    return mem[addr[AddrWidth-1:2]];
  endfunction

  always @(posedge clk)
  begin
    active = !reset;
    if (!reset && memValid && memReady && memWrite)
      mem[memAddr[AddrWidth-1:2]] = memWriteData;
  end

  // Completion delay of 0 to 3 cycles per request
  always @(negedge clk)
  begin
    if (!active)
    begin
      memReady = 1'b0;
      waiting  = 1'b0;
    end
    else if (memReady)
    begin
      memReady = 1'b0;
      waiting  = 1'b0;
    end
    else if (memValid)
    begin
      if (!waiting)
      begin
        waitLeft = int'(pickDelay());
        waiting  = 1'b1;
      end
      if (waitLeft == 0)
      begin
        memReady    = 1'b1;
        memReadData = mem[memAddr[AddrWidth-1:2]];
      end
      else
        waitLeft--;
    end
  end

endmodule

`default_nettype wire

// File: verilog/armCore.sv
`default_nettype none

module armCore #(
  parameter int AddrWidth = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic                 memValid,
  output logic                 memWrite,
  output logic [AddrWidth-1:0] memAddr,
  output armCorePkg::wordT     memWriteData,
  input  armCorePkg::wordT     memReadData,
  input  logic                 memReady,
  output logic                 halted
);

  // Control bundle and instruction fields between the two halves
  coreCtrlIf ctrlBus ();

  controlSequencer sequencer (
    .clk(clk),
    .reset(reset),
    .memReady(memReady),
    .memValid(memValid),
    .memWrite(memWrite),
    .halted(halted),
    .ctrl(ctrlBus)
  );

  coreDatapath #(
    .AddrWidth(AddrWidth)
  ) datapath (
    .clk(clk),
    .reset(reset),
    .memReadData(memReadData),
    .memReady(memReady),
    .memAddr(memAddr),
    .memWriteData(memWriteData),
    .ctrl(ctrlBus)
  );

endmodule

`default_nettype wire

// File: verilog/coreDatapath.sv
`default_nettype none

module coreDatapath #(
  parameter int AddrWidth = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  armCorePkg::wordT     memReadData,
  input  logic                 memReady,
  output logic [AddrWidth-1:0] memAddr,
  output armCorePkg::wordT     memWriteData,
  coreCtrlIf.dp                ctrl
);
  import armCorePkg::*;

  regIdxT rn;
  regIdxT rd;
  regIdxT rm;
  regIdxT readA;
  wordT   dataA;
  wordT   dataB;
  wordT   pc;
  wordT   pcPlus4;
  wordT   pcData;
  wordT   pcNext;
  wordT   operandA;
  wordT   operandB;
  wordT   aluResult;
  wordT   writeData;
  wordT   marIn;
  wordT   loadWord;
  logic   aluCarry;
  logic   pcWriteEn;
  logic [AddrWidth-1:0] mar;

  assign rn    = ctrl.instrWord[rnLsb +: 4];
  assign rd    = ctrl.instrWord[rdLsb +: 4];
  assign rm    = ctrl.instrWord[rmLsb +: 4];
  // Store data comes from Rd
  assign readA = ctrl.useRdAsA ? rd : rn;

  registerFile regFile (
    .clk(clk), .reset(reset), .readA(readA), .readB(rm),
    .writeIdx(rd), .writeData(writeData), .writeEn(ctrl.regWrite),
    .pcData(pcData), .pcWrite(pcWriteEn),
    .dataA(dataA), .dataB(dataB), .pc(pc)
  );

  operandShifter shifter (
    .instrWord(ctrl.instrWord), .regB(dataB),
    .operandSel(ctrl.operandSel), .operand(operandB)
  );

  // Branch target is relative to the already advanced PC
  assign operandA = (ctrl.operandSel == selBrOffset) ? pc : dataA;

  aluUnit alu (
    .a(operandA), .b(operandB), .op(ctrl.aluOp), .carryIn(ctrl.carry),
    .result(aluResult), .carryOut(aluCarry)
  );

  assign pcPlus4   = pc + 32'd4;
  assign pcWriteEn = ctrl.pcWrite | ctrl.pcIncrement;
  assign pcData    = ctrl.pcIncrement ? pcPlus4 : aluResult;
  assign writeData = (ctrl.aluOp == opPassA) ? loadWord : aluResult;

  // PC as it will be after this edge, so a write to R15 is seen by the next fetch
  assign pcNext = pcWriteEn ? pcData :
                  (ctrl.regWrite && rd == pcIndex) ? writeData : pc;
  assign marIn  = ctrl.marFromPc ? pcNext : aluResult;

  always_ff @(posedge clk)
  begin
    if (ctrl.irLoad)
      ctrl.instrWord <= memReadData;
    if (memReady)
      loadWord <= memReadData;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mar        <= '0;
      ctrl.carry <= 1'b0;
    end
    else
    begin
      if (ctrl.marLoad)
        mar <= marIn[AddrWidth-1:0];
      if (ctrl.flagLoad)
        ctrl.carry <= aluCarry;
    end
  end

  assign memAddr      = mar;
  assign memWriteData = dataA;

endmodule

`default_nettype wire

// File: verilog/controlSequencer.sv
`default_nettype none

module controlSequencer (
  input  logic      clk,
  input  logic      reset,
  input  logic      memReady,
  output logic      memValid,
  output logic      memWrite,
  output logic      halted,
  coreCtrlIf.seq    ctrl
);
  import armCorePkg::*;

  seqStateT   state;
  seqStateT   stateNext;
  instrClassT instrClass;
  aluOpT      dpOpcode;
  logic       isCompare;
  logic       isLoad;

  // Class from bits 27:25
  // Bit 25 is the I bit of data-processing
  always_comb
  begin
    case (ctrl.instrWord[classMsb:classLsb])
      3'b000, 3'b001: instrClass = dataProc;
      3'b010:         instrClass = loadStore;
      3'b101:         instrClass = branchOp;
      default:        instrClass = unknown;
    endcase
  end

  assign dpOpcode  = aluOpT'({1'b0, ctrl.instrWord[opcodeLsb +: 4]});
  assign isCompare = dpOpcode inside {opTst, opTeq, opCmp, opCmn};
  assign isLoad    = ctrl.instrWord[lBit];

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= stFetch;
    else
      state <= stateNext;
  end

  always_comb
  begin
    stateNext        = state;
    memValid         = 1'b0;
    memWrite         = 1'b0;
    halted           = 1'b0;
    ctrl.irLoad      = 1'b0;
    ctrl.marLoad     = 1'b0;
    ctrl.regWrite    = 1'b0;
    ctrl.pcWrite     = 1'b0;
    ctrl.pcIncrement = 1'b0;
    ctrl.flagLoad    = 1'b0;
    ctrl.aluOp       = opPassA;
    ctrl.operandSel  = selRegB;
    ctrl.useRdAsA    = 1'b0;
    ctrl.marFromPc   = 1'b0;
    case (state)
      stFetch:
      begin
        // No request while reset is held
        memValid = !reset;
        if (memReady)
        begin
          ctrl.irLoad      = 1'b1;
          ctrl.pcIncrement = 1'b1;
          stateNext        = stDecode;
        end
      end
      stDecode:
      begin
        // Point the address register at the next fetch
        ctrl.marLoad   = 1'b1;
        ctrl.marFromPc = 1'b1;
        if (ctrl.instrWord == haltInstr)
          stateNext = stHalted;
        else
        begin
          case (instrClass)
            dataProc:  stateNext = stExecDp;
            loadStore: stateNext = stMemAddrCalc;
            branchOp:  stateNext = stBranch;
            default:   stateNext = stFetch;
          endcase
        end
      end
      stExecDp:
      begin
        ctrl.aluOp      = dpOpcode;
        ctrl.operandSel = ctrl.instrWord[classLsb] ? selRotImm : selRegB;
        ctrl.regWrite   = !isCompare;
        ctrl.flagLoad   = ctrl.instrWord[sBit];
        ctrl.marLoad    = 1'b1;
        ctrl.marFromPc  = 1'b1;
        stateNext       = stFetch;
      end
      stMemAddrCalc:
      begin
        ctrl.aluOp      = opAddOffset;
        ctrl.operandSel = selLsOffset;
        ctrl.marLoad    = 1'b1;
        stateNext       = stMemAccess;
      end
      stMemAccess:
      begin
        memValid      = 1'b1;
        memWrite      = !isLoad;
        ctrl.useRdAsA = 1'b1;
        if (memReady)
        begin
          if (isLoad)
            stateNext = stWriteBack;
          else
          begin
            ctrl.marLoad   = 1'b1;
            ctrl.marFromPc = 1'b1;
            stateNext      = stFetch;
          end
        end
      end
      stWriteBack:
      begin
        // passA routes the captured read word to Rd
        ctrl.aluOp     = opPassA;
        ctrl.regWrite  = 1'b1;
        ctrl.marLoad   = 1'b1;
        ctrl.marFromPc = 1'b1;
        stateNext      = stFetch;
      end
      stBranch:
      begin
        ctrl.aluOp      = opAddOffset;
        ctrl.operandSel = selBrOffset;
        ctrl.pcWrite    = 1'b1;
        ctrl.marLoad    = 1'b1;
        ctrl.marFromPc  = 1'b1;
        stateNext       = stFetch;
      end
      default: halted = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/operandShifter.sv
`default_nettype none

module operandShifter (
  input  armCorePkg::wordT       instrWord,
  input  armCorePkg::wordT       regB,
  input  armCorePkg::operandSelT operandSel,
  output armCorePkg::wordT       operand
);
  import armCorePkg::*;

  wordT        imm8Ext;
  logic [4:0]  rotAmount;
  logic [63:0] rotPair;
  wordT        rotated;
  wordT        lsOffset;
  wordT        brOffset;

  assign imm8Ext   = {24'd0, instrWord[imm8Lsb +: 8]};
  // Rotate field counts in steps of two bits
  assign rotAmount = {instrWord[rotLsb +: 4], 1'b0};
  assign rotPair   = {imm8Ext, imm8Ext} >> rotAmount;
  assign rotated   = rotPair[31:0];

  assign lsOffset = {20'd0, instrWord[imm12Lsb +: 12]};
  assign brOffset = {{6{instrWord[imm24Lsb + 23]}}, instrWord[imm24Lsb +: 24], 2'b00};

  always_comb
  begin
    case (operandSel)
      selRotImm:   operand = rotated;
      selLsOffset: operand = lsOffset;
      selBrOffset: operand = brOffset;
      default:     operand = regB;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`default_nettype none

module registerFile (
  input  logic               clk,
  input  logic               reset,
  input  armCorePkg::regIdxT readA,
  input  armCorePkg::regIdxT readB,
  input  armCorePkg::regIdxT writeIdx,
  input  armCorePkg::wordT   writeData,
  input  logic               writeEn,
  input  armCorePkg::wordT   pcData,
  input  logic               pcWrite,
  output armCorePkg::wordT   dataA,
  output armCorePkg::wordT   dataB,
  output armCorePkg::wordT   pc
);
  import armCorePkg::*;

  wordT regs [16];

  // Later assignment wins, so pcWrite overrides a write to R15
  always_ff @(posedge clk)
  begin
    if (writeEn)
      regs[writeIdx] <= writeData;
    if (reset)
      regs[pcIndex] <= '0;
    else if (pcWrite)
      regs[pcIndex] <= pcData;
  end

  assign dataA = regs[readA];
  assign dataB = regs[readB];
  assign pc    = regs[pcIndex];

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
`default_nettype none

module aluUnit (
  input  armCorePkg::wordT  a,
  input  armCorePkg::wordT  b,
  input  armCorePkg::aluOpT op,
  input  logic              carryIn,
  output armCorePkg::wordT  result,
  output logic              carryOut
);
  import armCorePkg::*;

  wordT        addX;
  wordT        addY;
  logic        addCin;
  logic [32:0] sum;

  // One adder serves every arithmetic opcode
  always_comb
  begin
    addX   = a;
    addY   = b;
    addCin = 1'b0;
    case (op)
      opSub, opCmp:
      begin
        addY   = ~b;
        addCin = 1'b1;
      end
      opRsb:
      begin
        addX   = b;
        addY   = ~a;
        addCin = 1'b1;
      end
      opAdc: addCin = carryIn;
      opSbc:
      begin
        addY   = ~b;
        addCin = carryIn;
      end
      opRsc:
      begin
        addX   = b;
        addY   = ~a;
        addCin = carryIn;
      end
      default: addCin = 1'b0;
    endcase
  end

  // Carry out of a + ~b + 1 is already "not borrow"
  assign sum = {1'b0, addX} + {1'b0, addY} + {32'd0, addCin};

  always_comb
  begin
    carryOut = carryIn;
    case (op)
      opAnd, opTst: result = a & b;
      opEor, opTeq: result = a ^ b;
      opOrr:        result = a | b;
      opMov:        result = b;
      opBic:        result = a & ~b;
      opMvn:        result = ~b;
      opPassA:      result = a;
      default:
      begin
        result   = sum[31:0];
        carryOut = sum[32];
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/coreCtrlIf.sv
`default_nettype none

interface coreCtrlIf;
  import armCorePkg::*;

  logic       irLoad;
  logic       marLoad;
  logic       regWrite;
  logic       pcWrite;
  logic       pcIncrement;
  logic       flagLoad;
  aluOpT      aluOp;
  operandSelT operandSel;
  logic       useRdAsA;
  logic       marFromPc;

  // Back from the datapath
  wordT       instrWord;
  logic       carry;

  modport seq (
    output irLoad, marLoad, regWrite, pcWrite, pcIncrement, flagLoad,
    output aluOp, operandSel, useRdAsA, marFromPc,
    input  instrWord, carry
  );

  modport dp (
    input  irLoad, marLoad, regWrite, pcWrite, pcIncrement, flagLoad,
    input  aluOp, operandSel, useRdAsA, marFromPc,
    output instrWord, carry
  );

endinterface

`default_nettype wire

// File: verilog/armCorePkg.sv
`default_nettype none

package armCorePkg;

  typedef logic [31:0] wordT;
  typedef logic [3:0]  regIdxT;

  // ARM data-processing opcodes keep their instruction encoding
  typedef enum logic [4:0] {
    opAnd       = 5'h00,
    opEor       = 5'h01,
    opSub       = 5'h02,
    opRsb       = 5'h03,
    opAdd       = 5'h04,
    opAdc       = 5'h05,
    opSbc       = 5'h06,
    opRsc       = 5'h07,
    opTst       = 5'h08,
    opTeq       = 5'h09,
    opCmp       = 5'h0a,
    opCmn       = 5'h0b,
    opOrr       = 5'h0c,
    opMov       = 5'h0d,
    opBic       = 5'h0e,
    opMvn       = 5'h0f,
    opPassA     = 5'h10,
    opAddOffset = 5'h11
  } aluOpT;

  typedef enum logic [2:0] {
    stFetch,
    stDecode,
    stExecDp,
    stMemAddrCalc,
    stMemAccess,
    stWriteBack,
    stBranch,
    stHalted
  } seqStateT;

  typedef enum logic [1:0] {
    dataProc,
    loadStore,
    branchOp,
    unknown
  } instrClassT;

  typedef enum logic [1:0] {
    selRegB,
    selRotImm,
    selLsOffset,
    selBrOffset
  } operandSelT;

  // Instruction field positions
  localparam int unsigned opcodeLsb = 21;
  localparam int unsigned sBit      = 20;
  localparam int unsigned lBit      = 20;
  localparam int unsigned rnLsb     = 16;
  localparam int unsigned rdLsb     = 12;
  localparam int unsigned rmLsb     = 0;
  localparam int unsigned classMsb  = 27;
  localparam int unsigned classLsb  = 25;
  localparam int unsigned rotLsb    = 8;
  localparam int unsigned imm8Lsb   = 0;
  localparam int unsigned imm12Lsb  = 0;
  localparam int unsigned imm24Lsb  = 0;

  localparam regIdxT pcIndex = 4'd15;

  // B . with condition always
  localparam wordT haltInstr = 32'hEAFF_FFFF;

endpackage

`default_nettype wire
